//--- logic/apu_settings.svh
`ifndef APU_SETTINGS_SVH
`define APU_SETTINGS_SVH

`default_nettype none

`define APU_NUM_CH      4                                    // channel count
`define APU_LVL_W       7                                    // channel level width
`define APU_MIX_W       (`APU_LVL_W + $clog2(`APU_NUM_CH))   // mixed output width

// sample memory map
`define APU_SAMPLE_BASE 16'hC000
`define APU_ADDR_WRAP   16'h8000                             // next address after 16'hFFFF

`default_nettype wire

`endif

//--- logic/apu_pkg.sv
`default_nettype none

package apu_pkg;

	typedef enum logic [1:0] {
		REG_CTRL = 2'd0,
		REG_LOAD = 2'd1,
		REG_ADDR = 2'd2,
		REG_LEN  = 2'd3
	} reg_op_e;

	typedef enum logic {
		FILL_IDLE = 1'b0,
		FILL_WAIT = 1'b1
	} fill_state_e;

	typedef struct packed {
		logic       irq_en;
		logic       loop;
		logic [3:0] rate;
		logic [7:0] addr_reg;      // start = base + addr_reg * 64
		logic [7:0] len_reg;       // bytes = len_reg * 16 + 1
		logic       spare;
	} dmc_cfg_t;

	typedef struct packed {
		logic       en;
		logic       start;
		logic       load;
		logic [6:0] load_val;
		logic       irq_clr;
	} dmc_ctl_t;

	typedef struct packed {
		logic        req;
		logic [15:0] addr;
	} fetch_req_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} fetch_rsp_t;

	// NTSC bit period in ticks
	function automatic logic [8:0] rate_period(input logic [3:0] rate);
		case (rate)
			4'd0:    return 9'd428;
			4'd1:    return 9'd380;
			4'd2:    return 9'd340;
			4'd3:    return 9'd320;
			4'd4:    return 9'd286;
			4'd5:    return 9'd254;
			4'd6:    return 9'd226;
			4'd7:    return 9'd214;
			4'd8:    return 9'd190;
			4'd9:    return 9'd160;
			4'd10:   return 9'd142;
			4'd11:   return 9'd128;
			4'd12:   return 9'd106;
			4'd13:   return 9'd84;
			4'd14:   return 9'd72;
			default: return 9'd54;
		endcase
	endfunction

endpackage

`default_nettype wire

//--- logic/apu_dmc_regs.sv
`timescale 1ns/10ps
`include "apu_settings.svh"
`default_nettype none

module apu_dmc_regs (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  logic                   reg_wr,
	input  logic [1:0]             reg_ch,
	input  apu_pkg::reg_op_e       reg_op,
	input  logic [7:0]             reg_wdata,
	input  logic                   en_wr,
	input  logic [`APU_NUM_CH-1:0] en_mask,
	output apu_pkg::dmc_cfg_t      cfg [`APU_NUM_CH],
	output apu_pkg::dmc_ctl_t      ctl [`APU_NUM_CH]
);
	import apu_pkg::*;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			for (int i = 0; i < `APU_NUM_CH; i++) begin
				cfg[i] <= '0;
				ctl[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `APU_NUM_CH; i++) begin
				ctl[i].start   <= 1'b0;              // pulses last one cycle
				ctl[i].load    <= 1'b0;
				ctl[i].irq_clr <= 1'b0;
				if (reg_wr && reg_ch == 2'(i)) begin
					case (reg_op)
						REG_CTRL: begin
							cfg[i].irq_en <= reg_wdata[7];
							cfg[i].loop   <= reg_wdata[6];
							cfg[i].rate   <= reg_wdata[3:0];
							if (!reg_wdata[7])
								ctl[i].irq_clr <= 1'b1;  // irq off acks a pending irq
						end
						REG_LOAD: begin
							ctl[i].load     <= 1'b1;
							ctl[i].load_val <= reg_wdata[6:0];
						end
						REG_ADDR: cfg[i].addr_reg <= reg_wdata;
						REG_LEN:  cfg[i].len_reg  <= reg_wdata;
					endcase
				end
				if (en_wr) begin
					ctl[i].en      <= en_mask[i];
					ctl[i].start   <= en_mask[i];
					ctl[i].irq_clr <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/apu_dmc.sv
`timescale 1ns/10ps
`include "apu_settings.svh"
`default_nettype none

module apu_dmc (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  logic                  tick,
	input  apu_pkg::dmc_cfg_t     cfg,
	input  apu_pkg::dmc_ctl_t     ctl,
	output apu_pkg::fetch_req_t   fetch_req,
	input  apu_pkg::fetch_rsp_t   fetch_rsp,
	output logic [`APU_LVL_W-1:0] level,
	output logic                  act,
	output logic                  irq
);
	import apu_pkg::*;

	localparam logic [`APU_LVL_W-1:0] lvl_top = {`APU_LVL_W{1'b1}} - 2;   // highest level that may step up
	localparam logic [`APU_LVL_W-1:0] lvl_step = 2;

	fill_state_e fill_state;
	logic [15:0] addr;
	logic [11:0] len;
	logic [15:0] start_addr;
	logic [15:0] next_addr;
	logic [11:0] start_len;
	logic        fill_done;
	logic [7:0]  buf_data;
	logic        buf_full;
	logic [8:0]  timer;
	logic        expire;
	logic [7:0]  shift;
	logic [2:0]  bit_cnt;
	logic        silent;
	logic        take;

	assign start_addr = `APU_SAMPLE_BASE + {2'b00, cfg.addr_reg, 6'b0};
	assign start_len  = {cfg.len_reg, 4'b0} + 12'd1;
	assign next_addr  = (addr == 16'hFFFF) ? `APU_ADDR_WRAP : addr + 16'd1;
	assign fill_done  = fill_state == FILL_WAIT && fetch_rsp.valid;
	assign expire     = tick && timer == 9'd0;
	assign take       = expire && bit_cnt == 3'd0 && buf_full;

	// ************************************************************
	// memory reader

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			addr <= '0;
			len  <= '0;
			irq  <= 1'b0;
		end else begin
			if (!ctl.en)
				len <= '0;
			else if (fill_done && len != 12'd0) begin
				if (len == 12'd1 && cfg.loop) begin       // restart sample
					addr <= start_addr;
					len  <= start_len;
				end else begin
					addr <= next_addr;
					len  <= len - 12'd1;
				end
			end else if (ctl.start && len == 12'd0) begin
				addr <= start_addr;
				len  <= start_len;
			end
			if (ctl.en && fill_done && len == 12'd1 && !cfg.loop && cfg.irq_en)
				irq <= 1'b1;
			else if (ctl.irq_clr)
				irq <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			fill_state <= FILL_IDLE;
		else begin
			case (fill_state)
				FILL_IDLE: if (len != 12'd0 && !buf_full) fill_state <= FILL_WAIT;
				FILL_WAIT: if (fetch_rsp.valid) fill_state <= FILL_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			buf_full <= 1'b0;
		else if (fill_done)
			buf_full <= 1'b1;
		else if (take)
			buf_full <= 1'b0;                           // shifter took the byte
	end

	always_ff @(posedge sys_clk) begin
		if (fill_done)
			buf_data <= fetch_rsp.data;
	end

	assign fetch_req.req  = fill_state == FILL_WAIT;
	assign fetch_req.addr = addr;
	assign act            = len != 12'd0;

	// ************************************************************
	// output unit

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			timer   <= '0;
			bit_cnt <= '0;
			silent  <= 1'b1;
			level   <= '0;
		end else begin
			if (tick)
				timer <= (timer == 9'd0) ? rate_period(cfg.rate) - 9'd1 : timer - 9'd1;
			if (expire) begin
				if (bit_cnt == 3'd0) begin               // byte done, start next
					bit_cnt <= 3'd7;
					silent  <= !buf_full;
				end else
					bit_cnt <= bit_cnt - 3'd1;
			end
			if (ctl.load)
				level <= ctl.load_val;
			else if (expire && !silent) begin
				if (shift[0] && level <= lvl_top)
					level <= level + lvl_step;
				else if (!shift[0] && level >= lvl_step)
					level <= level - lvl_step;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (expire)
			shift <= take ? buf_data : {1'b0, shift[7:1]};
	end

endmodule

`default_nettype wire

//--- logic/apu_fetch_arb.sv
`timescale 1ns/10ps
`include "apu_settings.svh"
`default_nettype none

module apu_fetch_arb (
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  apu_pkg::fetch_req_t req [`APU_NUM_CH],
	output apu_pkg::fetch_rsp_t rsp [`APU_NUM_CH],
	output logic                mem_req,
	output logic [15:0]         mem_addr,
	input  logic                mem_ack,
	input  logic [7:0]          mem_rdata
);
	import apu_pkg::*;

	localparam int ch_w = $clog2(`APU_NUM_CH);

	logic            busy;                              // issue phase
	logic            ret;                               // return phase
	logic [ch_w-1:0] owner;
	logic [ch_w-1:0] ptr;                               // last channel served
	logic [ch_w-1:0] pick;
	logic            pick_ok;
	logic [7:0]      rdata_q;

	// next requester after ptr
	always_comb begin
		logic [ch_w-1:0] idx;
		pick_ok = 1'b0;
		pick    = ptr;
		for (int k = 1; k <= `APU_NUM_CH; k++) begin
			idx = ch_w'((int'(ptr) + k) % `APU_NUM_CH);
			if (!pick_ok && req[idx].req) begin
				pick_ok = 1'b1;
				pick    = idx;
			end
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy  <= 1'b0;
			ret   <= 1'b0;
			owner <= '0;
			ptr   <= ch_w'(`APU_NUM_CH - 1);            // channel 0 goes first
		end else begin
			ret <= 1'b0;
			if (busy) begin
				if (mem_ack) begin
					busy <= 1'b0;
					ret  <= 1'b1;
				end
			end else if (!ret && pick_ok) begin
				busy  <= 1'b1;
				owner <= pick;
				ptr   <= pick;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (busy && mem_ack)
			rdata_q <= mem_rdata;
	end

	assign mem_req  = busy;
	assign mem_addr = req[owner].addr;                  // owner holds addr until served

	always_comb begin
		for (int k = 0; k < `APU_NUM_CH; k++) begin
			rsp[k].valid = ret && owner == ch_w'(k);
			rsp[k].data  = rdata_q;
		end
	end

endmodule

`default_nettype wire

//--- logic/apu_mixer.sv
`timescale 1ns/10ps
`include "apu_settings.svh"
`default_nettype none

module apu_mixer (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  logic [`APU_LVL_W-1:0] level [`APU_NUM_CH],
	output logic [`APU_MIX_W-1:0] mix_out
);

	logic [`APU_MIX_W-1:0] sum;

	always_comb begin
		sum = '0;
		for (int k = 0; k < `APU_NUM_CH; k++)
			sum = sum + {{(`APU_MIX_W - `APU_LVL_W){1'b0}}, level[k]};
	end

	// one cycle behind the levels
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			mix_out <= '0;
		else
			mix_out <= sum;
	end

endmodule

`default_nettype wire

//--- logic/apu_dmc_top.sv
`timescale 1ns/10ps
`include "apu_settings.svh"
`default_nettype none

module apu_dmc_top (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  logic                   tick,
	input  logic                   reg_wr,
	input  logic [1:0]             reg_ch,
	input  apu_pkg::reg_op_e       reg_op,
	input  logic [7:0]             reg_wdata,
	input  logic                   en_wr,
	input  logic [`APU_NUM_CH-1:0] en_mask,
	output logic                   mem_req,
	output logic [15:0]            mem_addr,
	input  logic                   mem_ack,
	input  logic [7:0]             mem_rdata,
	output logic [`APU_NUM_CH-1:0] act,
	output logic [`APU_NUM_CH-1:0] irq,
	output logic [`APU_MIX_W-1:0]  mix_out
);
	import apu_pkg::*;

	dmc_cfg_t              cfg   [`APU_NUM_CH];
	dmc_ctl_t              ctl   [`APU_NUM_CH];
	fetch_req_t            req   [`APU_NUM_CH];
	fetch_rsp_t            rsp   [`APU_NUM_CH];
	logic [`APU_LVL_W-1:0] level [`APU_NUM_CH];

	apu_dmc_regs u_regs (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.reg_wr    (reg_wr),
		.reg_ch    (reg_ch),
		.reg_op    (reg_op),
		.reg_wdata (reg_wdata),
		.en_wr     (en_wr),
		.en_mask   (en_mask),
		.cfg       (cfg),
		.ctl       (ctl)
	);

	for (genvar g = 0; g < `APU_NUM_CH; g++) begin : g_ch
		apu_dmc u_dmc (
			.sys_clk   (sys_clk),
			.sys_rst_n (sys_rst_n),
			.tick      (tick),
			.cfg       (cfg[g]),
			.ctl       (ctl[g]),
			.fetch_req (req[g]),
			.fetch_rsp (rsp[g]),
			.level     (level[g]),
			.act       (act[g]),
			.irq       (irq[g])
		);
	end

	apu_fetch_arb u_arb (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.req       (req),
		.rsp       (rsp),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

	apu_mixer u_mix (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.level     (level),
		.mix_out   (mix_out)
	);

endmodule

`default_nettype wire

//--- verification/tb_apu_dmc_top.sv
`timescale 1ns/10ps
`include "apu_settings.svh"
`default_nettype none

module tb_apu_dmc_top;
	import apu_pkg::*;

	localparam int byte_cyc    = 8 * 54;                  // rate 15 with a tick every cycle
	localparam int run_bytes   = 70;                      // rough count of byte periods in all tests
	localparam int timeout_cyc = 2 * run_bytes * byte_cyc;

	logic                   sys_clk = 1'b0;
	logic                   sys_rst_n;
	logic                   tick;
	logic                   reg_wr;
	logic [1:0]             reg_ch;
	reg_op_e                reg_op;
	logic [7:0]             reg_wdata;
	logic                   en_wr;
	logic [`APU_NUM_CH-1:0] en_mask;
	logic                   mem_req;
	logic [15:0]            mem_addr;
	logic                   mem_ack = 1'b0;
	logic [7:0]             mem_rdata = 8'h00;
	logic [`APU_NUM_CH-1:0] act;
	logic [`APU_NUM_CH-1:0] irq;
	logic [`APU_MIX_W-1:0]  mix_out;

	logic [7:0]  mem [0:65535];
	logic [15:0] fetch_log [$];                           // every address the DUT asked for
	logic [31:0] lcg_state = 32'h46af;
	int          lat_left = 0;
	int          held [`APU_NUM_CH];                      // level each channel should hold
	int          cycle_cnt = 0;

	apu_dmc_top UUT (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tick      (tick),
		.reg_wr    (reg_wr),
		.reg_ch    (reg_ch),
		.reg_op    (reg_op),
		.reg_wdata (reg_wdata),
		.en_wr     (en_wr),
		.en_mask   (en_mask),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata),
		.act       (act),
		.irq       (irq),
		.mix_out   (mix_out)
	);

	always #5 sys_clk = ~sys_clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_eq(input string test, input logic [31:0] exp, input logic [31:0] got);
		if (exp !== got) begin
			$display("** Error: %s expected 0x%0h actual 0x%0h", test, exp, got);
			fail_stop("value mismatch");
		end
	endtask

	always @(posedge sys_clk) begin
		cycle_cnt++;
		if (cycle_cnt >= timeout_cyc)
			fail_stop($sformatf("timeout, run still going after %0d cycles", cycle_cnt));
	end

	// ************************************************************
	// sample memory with 1 to 3 cycles of latency

	always @(posedge sys_clk) begin
		#1;
		if (mem_ack)
			mem_ack = 1'b0;
		else if (mem_req) begin
			if (lat_left == 0) begin                      // new request
				lat_left = 1 + int'((lcg_next() >> 16) % 32'd3);
				fetch_log.push_back(mem_addr);
			end
			lat_left--;
			if (lat_left == 0) begin
				mem_ack   = 1'b1;
				mem_rdata = mem[mem_addr];
			end
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sys_clk);
		#1;
	endtask

	task automatic reg_write(input int ch, input reg_op_e op, input logic [7:0] data);
		reg_wr    = 1'b1;
		reg_ch    = 2'(ch);
		reg_op    = op;
		reg_wdata = data;
		@(posedge sys_clk);
		#1;
		reg_wr = 1'b0;
	endtask

	task automatic en_write(input logic [`APU_NUM_CH-1:0] mask);
		en_wr   = 1'b1;
		en_mask = mask;
		@(posedge sys_clk);
		#1;
		en_wr = 1'b0;
	endtask

	task automatic load_level(input int ch, input int val);
		reg_write(ch, REG_LOAD, {1'b1, 7'(val)});             // bit 7 must be ignored
		held[ch] = val;
	endtask

	function automatic int sum_held();
		int s;
		s = 0;
		for (int c = 0; c < `APU_NUM_CH; c++)
			s += held[c];
		return s;
	endfunction

	// level after playing nbytes from first with each byte lsb first
	task automatic model_level(input int start_lvl, input logic [15:0] first, input int nbytes,
			output int lvl);
		logic [7:0] b;
		lvl = start_lvl;
		for (int i = 0; i < nbytes; i++) begin
			b = mem[first + 16'(i)];
			repeat (8) begin
				if (b[0]) begin
					if (lvl <= 125)
						lvl += 2;
				end else if (lvl >= 2)
					lvl -= 2;
				b = b >> 1;
			end
		end
	endtask

	// ************************************************************
	// tests

	task automatic test_direct_load();
		load_level(0, 17);
		load_level(1, 64);
		load_level(2, 100);
		load_level(3, 127);
		wait_cycles(2);
		check_eq("direct_load", 32'(sum_held()), 32'(mix_out));
	endtask

	task automatic test_single(input string name, input logic irq_on);
		int n0;
		int lvl;
		load_level(0, 50);
		reg_write(0, REG_CTRL, irq_on ? 8'h8F : 8'h0F);
		reg_write(0, REG_ADDR, 8'h05);
		reg_write(0, REG_LEN, 8'h00);                         // one byte
		n0 = fetch_log.size();
		en_write(4'b0001);
		wait_cycles(1);
		check_eq(name, 32'(1), 32'(act[0]));
		check_eq(name, 32'(0), 32'(irq[0]));
		while (act[0])
			wait_cycles(1);
		check_eq(name, 32'(irq_on), 32'(irq[0]));
		wait_cycles(9 * byte_cyc);
		check_eq(name, 32'(1), 32'(fetch_log.size() - n0));
		check_eq(name, 32'hC140, 32'(fetch_log[n0]));
		model_level(50, 16'hC140, 1, lvl);
		held[0] = lvl;
		check_eq(name, 32'(sum_held()), 32'(mix_out));
		if (irq_on) begin
			reg_write(0, REG_CTRL, 8'h0F);                    // irq_en off acks it
			wait_cycles(1);
			check_eq(name, 32'(0), 32'(irq[0]));
		end
	endtask

	task automatic test_concurrent();
		logic [15:0] base [`APU_NUM_CH];
		int          start [`APU_NUM_CH];
		int          hits [`APU_NUM_CH * 17];
		int          n0;
		int          lvl;
		logic [15:0] a;
		logic        found;
		start = '{0, 40, 90, 127};
		for (int c = 0; c < `APU_NUM_CH; c++) begin
			base[c] = `APU_SAMPLE_BASE + 16'((c + 1) * 16 * 64);
			load_level(c, start[c]);
			reg_write(c, REG_CTRL, 8'h0F);
			reg_write(c, REG_ADDR, 8'((c + 1) * 16));
			reg_write(c, REG_LEN, 8'h01);                     // 17 bytes
		end
		mem[base[0]] = 8'h00;                                 // pins ch0 at the floor
		mem[base[3]] = 8'hFF;                                 // pins ch3 at the top
		for (int i = 0; i < `APU_NUM_CH * 17; i++)
			hits[i] = 0;
		n0 = fetch_log.size();
		en_write(4'hF);
		wait_cycles(1);
		check_eq("concurrent", 32'hF, 32'(act));
		while (act != '0)
			wait_cycles(1);
		wait_cycles(9 * byte_cyc);
		for (int k = n0; k < fetch_log.size(); k++) begin
			a = fetch_log[k];
			found = 1'b0;
			for (int c = 0; c < `APU_NUM_CH; c++) begin
				if (a >= base[c] && a < base[c] + 16'd17) begin
					hits[c * 17 + int'(a - base[c])]++;
					found = 1'b1;
				end
			end
			if (!found)
				fail_stop($sformatf("concurrent: address %h is outside every sample", a));
		end
		for (int i = 0; i < `APU_NUM_CH * 17; i++)
			check_eq("concurrent", 32'(1), 32'(hits[i]));
		for (int c = 0; c < `APU_NUM_CH; c++) begin
			model_level(start[c], base[c], 17, lvl);
			held[c] = lvl;
		end
		check_eq("concurrent", 32'(sum_held()), 32'(mix_out));
	endtask

	task automatic test_loop();
		int n0;
		int busy;
		reg_write(0, REG_CTRL, 8'h4F);                        // loop on at rate 15
		reg_write(0, REG_ADDR, 8'h08);
		reg_write(0, REG_LEN, 8'h01);
		n0 = fetch_log.size();
		en_write(4'b0001);
		while (fetch_log.size() < n0 + 19)
			wait_cycles(1);
		check_eq("loop", 32'(1), 32'(act[0]));
		for (int k = 0; k < 19; k++)
			check_eq("loop", 32'(16'hC200 + 16'(k % 17)), 32'(fetch_log[n0 + k]));
		en_write('0);
		wait_cycles(1);
		check_eq("loop", 32'(0), 32'(act[0]));
		wait_cycles(20);                                      // let a fetch in flight finish
		n0 = fetch_log.size();
		busy = 0;
		repeat (byte_cyc) begin
			wait_cycles(1);
			if (mem_req)
				busy++;
		end
		check_eq("loop", 32'(0), 32'(busy));
		check_eq("loop", 32'(n0), 32'(fetch_log.size()));
	endtask

	initial begin
		sys_rst_n = 1'b0;
		tick      = 1'b0;
		reg_wr    = 1'b0;
		reg_ch    = 2'd0;
		reg_op    = REG_CTRL;
		reg_wdata = 8'h00;
		en_wr     = 1'b0;
		en_mask   = '0;
		for (int a = 0; a < 65536; a++)
			mem[16'(a)] = 8'(lcg_next() >> 24);
		repeat (8) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;
		tick      = 1'b1;
		test_direct_load();
		test_single("single_sample", 1'b0);
		test_single("interrupt", 1'b1);
		test_concurrent();
		test_loop();
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+logic
logic/apu_pkg.sv
logic/apu_dmc_regs.sv
logic/apu_dmc.sv
logic/apu_fetch_arb.sv
logic/apu_mixer.sv
logic/apu_dmc_top.sv
verification/tb_apu_dmc_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_apu_dmc_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

SOURCES := $(wildcard logic/*.sv logic/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
